//--- verilog/snd_pkg.sv
package snd_pkg;

    // Sample and register widths
    localparam int SAMPLE_W = 16;
    localparam int DIV_W    = 4;
    localparam int APB_AW   = 4;
    localparam int APB_DW   = 32;

    // One enable every four clocks out of reset
    localparam logic [DIV_W-1:0] DIV_RESET = 4'd3;

    // Register byte addresses
    localparam logic [APB_AW-1:0] ADDR_CTRL   = 4'h0;
    localparam logic [APB_AW-1:0] ADDR_CLKDIV = 4'h4;

    // CTRL bit positions
    localparam int CTRL_EN_BIT     = 0;
    localparam int CTRL_SIGNED_BIT = 1;
    localparam int CTRL_STEREO_BIT = 2;

    typedef enum logic [APB_AW-1:0] {
        REG_CTRL   = ADDR_CTRL,
        REG_CLKDIV = ADDR_CLKDIV
    } snd_reg_e;

    // APB2 request, no PREADY or PSLVERR
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic             enable;
        logic             signed_in;
        logic             stereo;
        logic [DIV_W-1:0] clk_div;
    } snd_cfg_t;

    typedef struct packed {
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;
    } snd_pair_t;

endpackage

//--- verilog/snd_apb_regs.sv
module snd_apb_regs (
    input  logic                        clk_dac,
    input  logic                        rst,
    input  snd_pkg::apb_req_t           apb_i,
    output logic [snd_pkg::APB_DW-1:0]  prdata_o,
    output snd_pkg::snd_cfg_t           cfg_o
);
    import snd_pkg::*;

    snd_reg_e reg_addr;
    logic     wr_en;
    snd_cfg_t cfg_q;

    // Addresses outside the enum simply miss every case item
    assign reg_addr = snd_reg_e'(apb_i.paddr);

    // Write lands in the access phase without wait states
    assign wr_en = apb_i.psel & apb_i.penable & apb_i.pwrite;

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            cfg_q.enable    <= 1'b0;
            cfg_q.signed_in <= 1'b0;
            cfg_q.stereo    <= 1'b0;
            cfg_q.clk_div   <= DIV_RESET;
        end else if (wr_en) begin
            case (reg_addr)
                REG_CTRL: begin
                    cfg_q.enable    <= apb_i.pwdata[CTRL_EN_BIT];
                    cfg_q.signed_in <= apb_i.pwdata[CTRL_SIGNED_BIT];
                    cfg_q.stereo    <= apb_i.pwdata[CTRL_STEREO_BIT];
                end
                REG_CLKDIV: begin
                    cfg_q.clk_div <= apb_i.pwdata[DIV_W-1:0];
                end
                default: begin
                    // Unmapped address drops the write
                    cfg_q <= cfg_q;
                end
            endcase
        end
    end

    // Readback straight from the registers with unused bits zero
    always_comb begin
        prdata_o = '0;
        case (reg_addr)
            REG_CTRL: begin
                prdata_o[CTRL_EN_BIT]     = cfg_q.enable;
                prdata_o[CTRL_SIGNED_BIT] = cfg_q.signed_in;
                prdata_o[CTRL_STEREO_BIT] = cfg_q.stereo;
            end
            REG_CLKDIV: begin
                prdata_o[DIV_W-1:0] = cfg_q.clk_div;
            end
            default: begin
                prdata_o = '0;
            end
        endcase
    end

    assign cfg_o = cfg_q;

    // APB2 protocol checks on the requester side
    apb_penable_needs_psel: assert property (
        @(posedge clk_dac) disable iff (rst)
        apb_i.penable |-> apb_i.psel
    );

    // Address and direction hold from setup into access
    apb_setup_to_access_stable: assert property (
        @(posedge clk_dac) disable iff (rst)
        (apb_i.psel && !apb_i.penable) |=>
            (!apb_i.penable || ($stable(apb_i.paddr) && $stable(apb_i.pwrite)))
    );

endmodule

//--- verilog/snd_sample_fmt.sv
module snd_sample_fmt (
    input  logic                clk_dac,
    input  logic                rst,
    input  snd_pkg::snd_cfg_t   cfg_i,
    input  logic                cen_i,
    input  snd_pkg::snd_pair_t  raw_i,
    output snd_pkg::snd_pair_t  fmt_o
);
    import snd_pkg::*;

    snd_pair_t conv;
    snd_pair_t fmt_q;

    // Two's complement to offset binary is a flip of the MSB
    function automatic logic [SAMPLE_W-1:0] to_offset(
        input logic [SAMPLE_W-1:0] smp,
        input logic                is_signed
    );
        logic [SAMPLE_W-1:0] res;
        res = smp;
        res[SAMPLE_W-1] = smp[SAMPLE_W-1] ^ is_signed;
        return res;
    endfunction

    always_comb begin
        conv.left  = to_offset(raw_i.left, cfg_i.signed_in);
        conv.right = to_offset(raw_i.right, cfg_i.signed_in);
    end

    // Pair is taken once per modulator enable
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            fmt_q <= '0;
        end else if (!cfg_i.enable) begin
            // Silence while the path is off
            fmt_q <= '0;
        end else if (cen_i) begin
            fmt_q <= conv;
        end
    end

    assign fmt_o = fmt_q;

endmodule

//--- verilog/snd_sdm_dac.sv
module snd_sdm_dac (
    input  logic                            clk_dac,
    input  logic                            rst,
    input  logic                            cen_i,
    input  logic                            clr_i,
    input  logic [snd_pkg::SAMPLE_W-1:0]    pcm_i,
    output logic                            dac_o
);
    import snd_pkg::*;

    logic [SAMPLE_W-1:0] acc_q;
    logic [SAMPLE_W:0]   sum;
    logic                dac_q;

    // First order error feedback with the carry as output bit
    assign sum = {1'b0, acc_q} + {1'b0, pcm_i};

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            acc_q <= '0;
            dac_q <= 1'b0;
        end else if (clr_i) begin
            acc_q <= '0;
            dac_q <= 1'b0;
        end else if (cen_i) begin
            // Residue stays in the accumulator
            acc_q <= sum[SAMPLE_W-1:0];
            dac_q <= sum[SAMPLE_W];
        end
    end

    assign dac_o = dac_q;

    // Bit only moves on an update or a clear
    sdm_out_moves_on_cen: assert property (
        @(posedge clk_dac) disable iff (rst)
        $changed(dac_o) |-> ($past(cen_i) || $past(clr_i))
    );

endmodule

//--- verilog/snd_out_stage.sv
module snd_out_stage (
    input  logic                clk_dac,
    input  logic                rst,
    input  snd_pkg::snd_cfg_t   cfg_i,
    input  snd_pkg::snd_pair_t  fmt_i,
    output logic                cen_o,
    output logic                snd_pdm_left_o,
    output logic                snd_pdm_right_o
);
    import snd_pkg::*;

    logic [DIV_W-1:0] cnt_q;
    logic [DIV_W-1:0] div_q;
    logic             cen_q;
    logic             div_changed;
    logic             clr_left;
    logic             clr_right;
    logic             dac_left;
    logic             dac_right;

    // Divider restarts whenever a new period is loaded
    assign div_changed = (cfg_i.clk_div != div_q);

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
            div_q <= DIV_RESET;
            cen_q <= 1'b0;
        end else begin
            div_q <= cfg_i.clk_div;
            if (div_changed) begin
                cnt_q <= '0;
                cen_q <= 1'b0;
            end else if (cnt_q == div_q) begin
                cnt_q <= '0;
                cen_q <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
                cen_q <= 1'b0;
            end
        end
    end

    assign cen_o = cen_q;

    // Right modulator idles in mono
    assign clr_left  = ~cfg_i.enable;
    assign clr_right = ~cfg_i.enable | ~cfg_i.stereo;

    snd_sdm_dac u_sdm_left (
        .clk_dac ( clk_dac      ),
        .rst     ( rst          ),
        .cen_i   ( cen_q        ),
        .clr_i   ( clr_left     ),
        .pcm_i   ( fmt_i.left   ),
        .dac_o   ( dac_left     )
    );

    snd_sdm_dac u_sdm_right (
        .clk_dac ( clk_dac      ),
        .rst     ( rst          ),
        .cen_i   ( cen_q        ),
        .clr_i   ( clr_right    ),
        .pcm_i   ( fmt_i.right  ),
        .dac_o   ( dac_right    )
    );

    // Mute is immediate, mono copies the left bit
    assign snd_pdm_left_o  = cfg_i.enable & dac_left;
    assign snd_pdm_right_o = cfg_i.enable & (cfg_i.stereo ? dac_right : dac_left);

    // Enables are single cycle pulses unless the divider is zero
    cen_single_pulse: assert property (
        @(posedge clk_dac) disable iff (rst)
        (cen_o && (cfg_i.clk_div != '0)) |=> !cen_o
    );

endmodule

//--- verilog/snd_dac_top.sv
module snd_dac_top (
    input  logic                        clk_dac,
    input  logic                        rst,
    input  snd_pkg::apb_req_t           apb_i,
    output logic [snd_pkg::APB_DW-1:0]  prdata_o,
    input  snd_pkg::snd_pair_t          snd_i,
    output logic                        snd_pdm_left_o,
    output logic                        snd_pdm_right_o
);
    import snd_pkg::*;

    snd_cfg_t  cfg;
    snd_pair_t fmt;
    logic      cen;

    // Register side
    snd_apb_regs u_apb_regs (
        .clk_dac  ( clk_dac  ),
        .rst      ( rst      ),
        .apb_i    ( apb_i    ),
        .prdata_o ( prdata_o ),
        .cfg_o    ( cfg      )
    );

    // Sign handling and sample latch
    snd_sample_fmt u_sample_fmt (
        .clk_dac ( clk_dac ),
        .rst     ( rst     ),
        .cfg_i   ( cfg     ),
        .cen_i   ( cen     ),
        .raw_i   ( snd_i   ),
        .fmt_o   ( fmt     )
    );

    // Enable generator and the two modulators
    snd_out_stage u_out_stage (
        .clk_dac         ( clk_dac         ),
        .rst             ( rst             ),
        .cfg_i           ( cfg             ),
        .fmt_i           ( fmt             ),
        .cen_o           ( cen             ),
        .snd_pdm_left_o  ( snd_pdm_left_o  ),
        .snd_pdm_right_o ( snd_pdm_right_o )
    );

endmodule

//--- sim/tb_snd_dac.sv
module tb_snd_dac;
    import snd_pkg::*;

    localparam int unsigned SEED         = 13098;
    localparam int unsigned CEN_TIMEOUT  = 64;
    localparam int unsigned PINS_TIMEOUT = 256;
    localparam int unsigned WINDOW_BITS  = 256;

    // Mapped bits of each register
    localparam logic [APB_DW-1:0] CTRL_MASK   = 32'h0000_0007;
    localparam logic [APB_DW-1:0] CLKDIV_MASK = 32'h0000_000f;

    logic              clk_dac;
    logic              rst;
    apb_req_t          apb_req;
    logic [APB_DW-1:0] prdata;
    snd_pair_t         snd_in;
    logic              pdm_left;
    logic              pdm_right;

    string             test_name;
    logic              en_model;
    logic              mono_check;

    snd_dac_top u_snd_dac_top (
        .clk_dac         ( clk_dac   ),
        .rst             ( rst       ),
        .apb_i           ( apb_req   ),
        .prdata_o        ( prdata    ),
        .snd_i           ( snd_in    ),
        .snd_pdm_left_o  ( pdm_left  ),
        .snd_pdm_right_o ( pdm_right )
    );

    always #50 clk_dac = ~clk_dac;

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input int unsigned expected,
                                   input int unsigned actual);
        stop_with_error($sformatf("error: %s expected %0d actual %0d", name, expected, actual));
    endtask

    task automatic check_equal(input int unsigned expected, input int unsigned actual);
        assert (actual == expected)
            else report_mismatch(test_name, expected, actual);
    endtask

    task automatic check_within(input int unsigned expected, input int unsigned actual,
                                input int unsigned tol);
        assert ((actual + tol >= expected) && (actual <= expected + tol))
            else report_mismatch(test_name, expected, actual);
    endtask

    // Enable bit as the APB writes leave it
    always @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            en_model <= 1'b0;
        end else if (apb_req.psel && apb_req.penable && apb_req.pwrite
                     && (apb_req.paddr == REG_CTRL)) begin
            en_model <= apb_req.pwdata[CTRL_EN_BIT];
        end
    end

    pins_low_when_off: assert property (
        @(posedge clk_dac) disable iff (rst)
        !en_model |-> (!pdm_left && !pdm_right)
    ) else stop_with_error("a sound pin is high while the output is disabled");

    right_follows_left_in_mono: assert property (
        @(posedge clk_dac) disable iff (rst)
        mono_check |-> (pdm_right == pdm_left)
    ) else stop_with_error("right pin differs from the left pin in mono mode");

    // Two cycle APB2 transfer without wait states
    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
        @(posedge clk_dac);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b1;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        @(posedge clk_dac);
        apb_req.penable <= 1'b1;
        // Register takes the data on this edge
        @(posedge clk_dac);
        apb_req <= '0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
        @(posedge clk_dac);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b0;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= '0;
        @(posedge clk_dac);
        apb_req.penable <= 1'b1;
        // Read data is valid within the access phase
        @(negedge clk_dac);
        data = prdata;
        @(posedge clk_dac);
        apb_req <= '0;
    endtask

    task automatic read_expect(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] expected);
        logic [APB_DW-1:0] data;
        apb_read(addr, data);
        check_equal(expected, data);
    endtask

    // Ones in 256 enables from a cleared accumulator times the bit hold period
    function automatic int unsigned expected_ones(input logic [SAMPLE_W-1:0] x,
                                                  input logic is_signed,
                                                  input int unsigned period);
        int unsigned level;
        level = 32'(x);
        if (is_signed) begin
            level = level ^ 32'h0000_8000;
        end
        return period * ((level * WINDOW_BITS) >> SAMPLE_W);
    endfunction

    task automatic wait_for_cen();
        int unsigned waited;
        logic        found;
        waited = 0;
        found  = 1'b0;
        while (!found && (waited < CEN_TIMEOUT)) begin
            @(negedge clk_dac);
            found  = (u_snd_dac_top.cen === 1'b1);
            waited = waited + 1;
        end
        if (!found) begin
            stop_with_error($sformatf("no clock enable seen within %0d cycles in %s",
                                      CEN_TIMEOUT, test_name));
        end
    endtask

    task automatic wait_for_pins_high();
        int unsigned waited;
        logic        found;
        waited = 0;
        found  = 1'b0;
        while (!found && (waited < PINS_TIMEOUT)) begin
            @(negedge clk_dac);
            found  = (pdm_left === 1'b1) && (pdm_right === 1'b1);
            waited = waited + 1;
        end
        if (!found) begin
            stop_with_error($sformatf("sound pins never both high within %0d cycles in %s",
                                      PINS_TIMEOUT, test_name));
        end
    endtask

    task automatic measure_ones(input int unsigned period, output int unsigned ones_left,
                                output int unsigned ones_right);
        ones_left  = 0;
        ones_right = 0;
        // Window opens after the second enable since the first adds the cleared sample
        wait_for_cen();
        wait_for_cen();
        repeat (WINDOW_BITS * period) begin
            @(negedge clk_dac);
            if (pdm_left) begin
                ones_left = ones_left + 1;
            end
            if (pdm_right) begin
                ones_right = ones_right + 1;
            end
        end
    endtask

    task automatic run_density(input string name, input logic [DIV_W-1:0] div,
                               input logic is_signed, input logic stereo,
                               input logic [SAMPLE_W-1:0] left,
                               input logic [SAMPLE_W-1:0] right);
        logic [APB_DW-1:0] mode;
        int unsigned       period;
        int unsigned       ones_left;
        int unsigned       ones_right;
        int unsigned       exp_left;
        int unsigned       exp_right;
        test_name  = name;
        period     = 32'(div) + 1;
        mono_check = 1'b0;
        mode       = '0;
        mode[CTRL_SIGNED_BIT] = is_signed;
        mode[CTRL_STEREO_BIT] = stereo;
        // Disabled first so both modulators start from zero
        apb_write(REG_CTRL, mode);
        apb_write(REG_CLKDIV, 32'(div));
        @(posedge clk_dac);
        snd_in.left  <= left;
        snd_in.right <= right;
        mode[CTRL_EN_BIT] = 1'b1;
        apb_write(REG_CTRL, mode);
        mono_check = !stereo;
        measure_ones(period, ones_left, ones_right);
        exp_left  = expected_ones(left, is_signed, period);
        exp_right = stereo ? expected_ones(right, is_signed, period) : exp_left;
        test_name = {name, " left"};
        check_within(exp_left, ones_left, period);
        test_name = {name, " right"};
        check_within(exp_right, ones_right, period);
    endtask

    task automatic random_pair(output logic [SAMPLE_W-1:0] left,
                               output logic [SAMPLE_W-1:0] right);
        left  = SAMPLE_W'($urandom());
        right = SAMPLE_W'($urandom());
        if (right == left) begin
            right = left ^ 16'h5a5a;
        end
    endtask

    initial begin
        logic [APB_DW-1:0]   wdata;
        logic [APB_DW-1:0]   ctrl_last;
        logic [APB_DW-1:0]   div_last;
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;

        void'($urandom(SEED));
        clk_dac    = 1'b0;
        rst       <= 1'b1;
        apb_req   <= '0;
        snd_in    <= '0;
        mono_check = 1'b0;
        ctrl_last  = '0;
        div_last   = '0;
        test_name  = "reset_state";
        repeat (8) @(posedge clk_dac);
        rst <= 1'b0;

        // Outputs idle and registers at their reset values
        repeat (16) begin
            @(negedge clk_dac);
            check_equal(0, 32'({pdm_left, pdm_right}));
        end
        read_expect(REG_CTRL, 32'd0);
        read_expect(REG_CLKDIV, 32'd3);

        test_name = "reg_access";
        for (int i = 0; i < 4; i++) begin
            wdata = $urandom();
            apb_write(REG_CTRL, wdata);
            ctrl_last = wdata & CTRL_MASK;
            read_expect(REG_CTRL, ctrl_last);
            wdata = $urandom();
            apb_write(REG_CLKDIV, wdata);
            div_last = wdata & CLKDIV_MASK;
            read_expect(REG_CLKDIV, div_last);
        end

        // Unmapped space drops writes and reads zero
        test_name = "unmapped";
        apb_write(4'h8, $urandom());
        read_expect(4'h8, 32'd0);
        read_expect(4'hc, 32'd0);
        read_expect(4'h2, 32'd0);
        read_expect(REG_CTRL, ctrl_last);
        read_expect(REG_CLKDIV, div_last);

        for (int i = 0; i < 2; i++) begin
            random_pair(left, right);
            run_density("unsigned_stereo", 4'd3, 1'b0, 1'b1, left, right);
        end

        // Signed zero lands at mid scale
        random_pair(left, right);
        run_density("signed_zero", 4'd3, 1'b1, 1'b1, 16'h0000, right);
        run_density("signed_random", 4'd3, 1'b1, 1'b1, left, right);

        random_pair(left, right);
        run_density("mono", 4'd3, 1'b0, 1'b0, left, right);

        random_pair(left, right);
        run_density("div7", 4'd7, 1'b0, 1'b1, left, right);

        // Full scale keeps both pins busy right up to the mute
        test_name = "disable";
        @(posedge clk_dac);
        snd_in <= '1;
        wait_for_pins_high();
        apb_write(REG_CTRL, 32'h0000_0004);
        // Mute takes effect on the cycle after the write
        repeat (8) begin
            @(negedge clk_dac);
            check_equal(0, 32'({pdm_left, pdm_right}));
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- files.f
verilog/snd_pkg.sv
verilog/snd_apb_regs.sv
verilog/snd_sample_fmt.sv
verilog/snd_sdm_dac.sv
verilog/snd_out_stage.sv
verilog/snd_dac_top.sv
sim/tb_snd_dac.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the sound DAC testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --assert --timing \
    --top-module tb_snd_dac \
    --Mdir obj_dir \
    -o Vtb_snd_dac \
    -f files.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_snd_dac
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished"
exit 0
